/* uart_pkg.sv */
//############################
// Shared types and constants for the UART core
// Imported by the RTL modules and the testbench
//############################

package uart_pkg;

  // One data character
  typedef logic [7:0] byte_t;

  // Bit 1 means parity present, bit 0 means odd, value 1 is also none
  typedef enum logic [1:0] {
    PARITY_NONE = 2'd0,
    PARITY_EVEN = 2'd2,
    PARITY_ODD  = 2'd3
  } parity_t;

  typedef logic [3:0] sample_cnt_t;  // Tick within a bit period
  typedef logic [2:0] bit_cnt_t;     // Data bit index

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP1,
    RX_STOP2
  } rx_state_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP1,
    TX_STOP2
  } tx_state_t;

  // Ticks per bit, both engines
  localparam logic [15:0] OVERSAMPLE = 16'd16;

endpackage

/* baud_tick_gen.sv */
//############################
// Baud tick source, one clock wide pulse
// at 16 times the bit rate for TX and RX
//############################

module baud_tick_gen #(
  parameter int CLKS_PER_TICK = 4  // Clock divisor, at least 1
) (
  input  logic clock,
  input  logic reset,
  output logic tick
);

  // Counter wide enough for the reload value
  localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_TICK - 1);

  logic [CW-1:0] div_cnt;

  // Down-counter, reloads after reaching zero
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt <= RELOAD;
    end else if (div_cnt == '0) begin
      div_cnt <= RELOAD;
    end else begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // Divisor of 1 keeps the counter at zero, tick always high
  assign tick = (div_cnt == '0);

endmodule

/* uart_tx.sv */
//############################
// UART transmitter, valid/ready byte input
// Sends start, 8 data LSB first, parity, stop bits
//############################

module uart_tx import uart_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    tick,         // 16x bit rate
  // Frame format
  input  parity_t parity_type,
  input  logic    nstop,        // 0: one stop bit, 1: two
  // Byte input
  input  byte_t   tx_data,
  input  logic    tx_valid,
  output logic    tx_ready,
  // Serial line
  output logic    txd
);

  localparam sample_cnt_t LAST_CNT = sample_cnt_t'(OVERSAMPLE - 1);

  tx_state_t   state;
  sample_cnt_t sample_cnt;
  bit_cnt_t    bit_cnt;
  byte_t       shift_reg;
  logic        parity_bit;
  logic        bit_end;  // Last tick of the current bit
  logic        load;

  assign tx_ready = (state == TX_IDLE);
  assign load     = tx_valid & tx_ready;
  assign bit_end  = tick & (sample_cnt == LAST_CNT);

  // Payload, loaded at the handshake
  always_ff @(posedge clock) begin
    if (load) begin
      shift_reg  <= tx_data;
      parity_bit <= (^tx_data) ^ parity_type[0];  // Odd mode inverts
    end else if (state == TX_DATA && bit_end) begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

  // Bit period counter, held at zero while idle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sample_cnt <= '0;
    end else if (state == TX_IDLE) begin
      sample_cnt <= '0;
    end else if (tick) begin
      sample_cnt <= sample_cnt + 1'b1;  // Wraps after 15
    end
  end

  // Frame FSM, txd registered
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= TX_IDLE;
      txd     <= 1'b1;  // Line idles high
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (load) begin
            state   <= TX_START;
            txd     <= 1'b0;  // Start bit
            bit_cnt <= '0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state <= TX_DATA;
            txd   <= shift_reg[0];  // LSB first
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (&bit_cnt) begin
              if (parity_type[1]) begin
                state <= TX_PARITY;
                txd   <= parity_bit;
              end else begin
                state <= TX_STOP1;
                txd   <= 1'b1;
              end
            end else begin
              txd <= shift_reg[1];  // Next bit before the shift lands
            end
          end
        end
        TX_PARITY: begin
          if (bit_end) begin
            state <= TX_STOP1;
            txd   <= 1'b1;
          end
        end
        TX_STOP1: begin
          if (bit_end) begin
            state <= nstop ? TX_STOP2 : TX_IDLE;
          end
        end
        TX_STOP2: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
          txd   <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* uart_rx.sv */
//############################
// UART receiver, 16x oversampling with 2 of 3 vote
// Reports each frame with parity and framing flags
//############################

module uart_rx import uart_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    tick,               // 16x bit rate
  // Frame format
  input  logic    rx_en,
  input  parity_t parity_type,
  input  logic    nstop,              // 0: one stop bit, 1: two
  // Serial line
  input  logic    rxd,
  // Finished frame
  output byte_t   frame_data,
  output logic    frame_parity_error,
  output logic    frame_frame_error,
  output logic    frame_done          // One cycle per frame
);

  localparam sample_cnt_t LAST_CNT  = sample_cnt_t'(OVERSAMPLE - 1);
  localparam sample_cnt_t SAMPLE_LO = sample_cnt_t'(OVERSAMPLE / 2 - 1);  // 7
  localparam sample_cnt_t SAMPLE_HI = sample_cnt_t'(OVERSAMPLE / 2 + 1);  // 9

  rx_state_t   state, next_state;
  logic        rxd_meta, rxd_sync;
  sample_cnt_t sample_cnt;
  bit_cnt_t    bit_cnt;
  logic [2:0]  samples;       // Three samples around the centre
  logic        sampled_bit;
  logic        sample_end;    // Bit decision point
  logic        frame_start;   // Start bit confirmed
  logic        frame_end;
  byte_t       data_reg;
  logic        parity_er;
  logic        framing_er;

  // Two flop synchroniser
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // Majority vote, 2 of 3
  assign sampled_bit = (samples[0] & samples[1]) |
                       (samples[0] & samples[2]) |
                       (samples[1] & samples[2]);

  assign sample_end  = tick & (sample_cnt == LAST_CNT);
  assign frame_start = (state == RX_START) & sample_end & ~sampled_bit;

  // Tick counter, restarts on the start edge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sample_cnt <= '0;
    end else if (state == RX_IDLE) begin
      sample_cnt <= '0;
    end else if (tick) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // Sample shifter and data shift register
  always_ff @(posedge clock) begin
    if (tick && sample_cnt >= SAMPLE_LO && sample_cnt <= SAMPLE_HI) begin
      samples <= {rxd_sync, samples[2:1]};  // Vote is order free
    end
    if (state == RX_DATA && sample_end) begin
      data_reg <= {sampled_bit, data_reg[7:1]};  // LSB arrives first
    end
  end

  // Data bit index
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bit_cnt <= '0;
    end else if (frame_start) begin
      bit_cnt <= '0;
    end else if (state == RX_DATA && sample_end) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Error flags, cleared when a new frame starts
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      parity_er  <= 1'b0;
      framing_er <= 1'b0;
    end else if (frame_start) begin
      parity_er  <= 1'b0;
      framing_er <= 1'b0;
    end else if (sample_end) begin
      if (state == RX_PARITY) begin
        parity_er <= (^data_reg) ^ parity_type[0] ^ sampled_bit;
      end
      if (state == RX_STOP1) begin
        framing_er <= ~sampled_bit;
      end
      // Stop2 only checked after a good stop1
      if (state == RX_STOP2 && !framing_er) begin
        framing_er <= ~sampled_bit;
      end
    end
  end

  // State register and done pulse
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= RX_IDLE;
      frame_done <= 1'b0;
    end else begin
      state      <= next_state;
      frame_done <= frame_end;
    end
  end

  // Next state
  always_comb begin
    next_state = state;
    frame_end  = 1'b0;
    case (state)
      RX_IDLE: begin
        if (!rxd_sync && rx_en) begin
          next_state = RX_START;
        end
      end
      RX_START: begin
        if (sample_end) begin
          next_state = sampled_bit ? RX_IDLE : RX_DATA;  // High means false start
        end
      end
      RX_DATA: begin
        if (sample_end && (&bit_cnt)) begin
          next_state = parity_type[1] ? RX_PARITY : RX_STOP1;
        end
      end
      RX_PARITY: begin
        if (sample_end) begin
          next_state = RX_STOP1;
        end
      end
      RX_STOP1: begin
        if (sample_end) begin
          if (nstop) begin
            next_state = RX_STOP2;
          end else begin
            next_state = RX_IDLE;
            frame_end  = 1'b1;
          end
        end
      end
      RX_STOP2: begin
        if (sample_end) begin
          next_state = RX_IDLE;
          frame_end  = 1'b1;
        end
      end
      default: next_state = RX_IDLE;
    endcase
  end

  assign frame_data         = data_reg;
  assign frame_parity_error = parity_er;
  assign frame_frame_error  = framing_er;

endmodule

/* rx_queue.sv */
//############################
// Receive FIFO of frames and their error flags
// Drained through a valid/ready port, sticky overrun
//############################

module rx_queue import uart_pkg::*; #(
  parameter int QUEUE_DEPTH = 4  // Power of two, at least 2
) (
  input  logic  clock,
  input  logic  reset,
  // From the receiver, no back-pressure
  input  logic  push,
  input  byte_t push_data,
  input  logic  push_parity_error,
  input  logic  push_frame_error,
  // Consumer side
  output byte_t rx_data,
  output logic  rx_parity_error,
  output logic  rx_frame_error,
  output logic  rx_valid,
  input  logic  rx_ready,
  output logic  rx_overrun
);

  localparam int AW = $clog2(QUEUE_DEPTH);
  localparam int EW = $bits(byte_t) + 2;  // Data plus two flags

  logic [EW-1:0] mem [QUEUE_DEPTH];
  logic [AW:0]   wr_ptr, rd_ptr;  // Extra bit tells full from empty
  logic          full, empty;
  logic          wr_en, rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign wr_en = push & ~full;
  assign rd_en = rx_valid & rx_ready;

  // Storage
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= {push_parity_error, push_frame_error, push_data};
    end
  end

  // Pointers and overrun
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      rx_overrun <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && full) begin
        rx_overrun <= 1'b1;  // Frame dropped, held until reset
      end
    end
  end

  // Head entry drives the outputs
  assign {rx_parity_error, rx_frame_error, rx_data} = mem[rd_ptr[AW-1:0]];
  assign rx_valid = ~empty;

endmodule

/* uart_core.sv */
//############################
// UART core top level, tick source, TX, RX
// and receive FIFO wired together
//############################

module uart_core import uart_pkg::*; #(
  parameter int CLKS_PER_TICK = 4,  // Clocks per 16x tick
  parameter int QUEUE_DEPTH   = 4   // Receive FIFO entries
) (
  input  logic    clock,
  input  logic    reset,
  // Static configuration
  input  logic    rx_en,
  input  parity_t parity_type,
  input  logic    nstop,
  // Serial
  input  logic    rxd,
  output logic    txd,
  // Transmit byte port
  input  byte_t   tx_data,
  input  logic    tx_valid,
  output logic    tx_ready,
  // Receive entry port
  output byte_t   rx_data,
  output logic    rx_parity_error,
  output logic    rx_frame_error,
  output logic    rx_valid,
  input  logic    rx_ready,
  output logic    rx_overrun
);

  logic  tick;
  logic  frame_done;
  byte_t frame_data;
  logic  frame_parity_error;
  logic  frame_frame_error;

  baud_tick_gen #(
    .CLKS_PER_TICK(CLKS_PER_TICK)
  ) u_baud_tick_gen (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  uart_tx u_uart_tx (
    .clock       (clock),
    .reset       (reset),
    .tick        (tick),
    .parity_type (parity_type),
    .nstop       (nstop),
    .tx_data     (tx_data),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .txd         (txd)
  );

  uart_rx u_uart_rx (
    .clock              (clock),
    .reset              (reset),
    .tick               (tick),
    .rx_en              (rx_en),
    .parity_type        (parity_type),
    .nstop              (nstop),
    .rxd                (rxd),
    .frame_data         (frame_data),
    .frame_parity_error (frame_parity_error),
    .frame_frame_error  (frame_frame_error),
    .frame_done         (frame_done)
  );

  // Frames drop here when the FIFO is full
  rx_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_rx_queue (
    .clock             (clock),
    .reset             (reset),
    .push              (frame_done),
    .push_data         (frame_data),
    .push_parity_error (frame_parity_error),
    .push_frame_error  (frame_frame_error),
    .rx_data           (rx_data),
    .rx_parity_error   (rx_parity_error),
    .rx_frame_error    (rx_frame_error),
    .rx_valid          (rx_valid),
    .rx_ready          (rx_ready),
    .rx_overrun        (rx_overrun)
  );

endmodule

/* uart_core_sva.sv */
//############################
// Port protocol checks for the UART core
// Bound into every uart_core instance
//############################

module uart_core_sva import uart_pkg::*; (
  input logic  clock,
  input logic  reset,
  input logic  txd,
  input logic  tx_valid,
  input logic  tx_ready,
  input byte_t rx_data,
  input logic  rx_parity_error,
  input logic  rx_frame_error,
  input logic  rx_valid,
  input logic  rx_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  int error_count = 0;  // Failed checks, read by the testbench

  // Idle line is high, a frame opens with its start bit
  a_idle_line_high: assert property (
    @(posedge clock) disable iff (reset) tx_ready |-> txd
  ) else begin
    $error("txd low while the transmitter is idle");
    error_count++;
  end

  a_frame_starts_low: assert property (
    @(posedge clock) disable iff (reset) $fell(tx_ready) |-> !txd
  ) else begin
    $error("Transmit frame began without a start bit");
    error_count++;
  end

  a_tx_busy_after_load: assert property (
    @(posedge clock) disable iff (reset) (tx_valid && tx_ready) |=> !tx_ready
  ) else begin
    $error("tx_ready still high after a transmit handshake");
    error_count++;
  end

  // Head entry held under back-pressure
  a_rx_hold: assert property (
    @(posedge clock) disable iff (reset)
      (rx_valid && !rx_ready) |=> rx_valid && $stable(rx_data) &&
                                  $stable(rx_parity_error) && $stable(rx_frame_error)
  ) else begin
    $error("Receive entry changed while stalled");
    error_count++;
  end

  // Pointers settle on the first reset edge
  a_rx_quiet_in_reset: assert property (
    @(posedge clock) reset |=> !rx_valid
  ) else begin
    $error("rx_valid high during reset");
    error_count++;
  end

  a_rx_quiet_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> !rx_valid
  ) else begin
    $error("rx_valid high right after reset");
    error_count++;
  end

endmodule

bind uart_core uart_core_sva u_uart_core_sva (.*);

/* tb_uart_core.sv */
//############################
// Testbench for the UART core, loopback and driven frames
// Checks each receive entry by assertion against a model
//############################

module tb_uart_core import uart_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_TICK  = 2;
  localparam int QUEUE_DEPTH    = 4;
  localparam int TICKS_PER_BIT  = int'(OVERSAMPLE);
  localparam int BIT_CLKS       = TICKS_PER_BIT * CLKS_PER_TICK;  // 32 clocks per bit
  localparam int TIMEOUT_CYCLES = 40 * 12 * BIT_CLKS * 2;         // 40 frames, 2x margin

  logic    clock;
  logic    reset;
  logic    rx_en;
  parity_t parity_type;
  logic    nstop;
  logic    rxd;
  logic    txd;
  byte_t   tx_data;
  logic    tx_valid;
  logic    tx_ready;
  byte_t   rx_data;
  logic    rx_parity_error;
  logic    rx_frame_error;
  logic    rx_valid;
  logic    rx_ready;
  logic    rx_overrun;

  logic    use_loopback;  // 1: rxd from txd, 0: serial driver below
  logic    rxd_drv;
  integer  seed = 32'hc9b;
  string   test_name;
  int      cycle_count = 0;

  // Expected entries {parity_error, frame_error, data}
  logic [9:0] exp_mem [64];
  int         exp_wr = 0;
  int         exp_rd = 0;
  logic [9:0] exp_head;
  logic [9:0] rx_entry;

  assign rxd      = use_loopback ? txd : rxd_drv;
  assign exp_head = exp_mem[exp_rd];
  assign rx_entry = {rx_parity_error, rx_frame_error, rx_data};

  uart_core #(
    .CLKS_PER_TICK(CLKS_PER_TICK),
    .QUEUE_DEPTH  (QUEUE_DEPTH)
  ) u_uart_core (.*);

  always #2 clock = ~clock;  // 4 ns period

  task automatic stop_on_failure(string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Watchdog
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      stop_on_failure("Timeout, the run did not finish within the cycle limit");
    end
  end

  // Bound protocol checker counts its failures
  always @(negedge clock) begin
    if (u_uart_core.u_uart_core_sva.error_count != 0) begin
      stop_on_failure("A protocol assertion on the DUT ports failed");
    end
  end

  // Model pops with each receive handshake
  always @(posedge clock) begin
    if (!reset && rx_valid && rx_ready) begin
      exp_rd <= exp_rd + 1;
    end
  end

  no_unexpected_entry: assert property (
    @(posedge clock) disable iff (reset) rx_valid |-> (exp_rd != exp_wr)
  ) else begin
    stop_on_failure("Receive FIFO holds an entry that no test expects");
  end

  entry_matches: assert property (
    @(posedge clock) disable iff (reset) (rx_valid && rx_ready) |-> (rx_entry == exp_head)
  ) else begin
    stop_on_failure($sformatf("Error %s expected %h actual %h", test_name,
                              $sampled(exp_head), $sampled(rx_entry)));
  end

  // Even mode: ones count with this bit is even, odd mode: odd
  function automatic logic parity_bit_for(byte_t data, parity_t mode);
    return (^data) ^ (mode == PARITY_ODD);
  endfunction

  // Entry the receiver should report for a frame as it goes on the line
  function automatic logic [9:0] reference_entry(byte_t data, logic par_bit,
                                                 logic stop1, logic stop2);
    logic par_err;
    logic frm_err;
    par_err = (parity_type inside {PARITY_EVEN, PARITY_ODD}) &&
              (par_bit != parity_bit_for(data, parity_type));
    frm_err = !stop1 || (nstop && !stop2);  // Stop2 only matters after a good stop1
    return {par_err, frm_err, data};
  endfunction

  task automatic expect_entry(logic [9:0] entry);
    exp_mem[exp_wr] = entry;
    exp_wr++;
  endtask

  task automatic set_format(parity_t mode, logic two_stop);
    parity_type = mode;
    nstop       = two_stop;
    @(negedge clock);
  endtask

  task automatic wait_drained();
    while (exp_rd != exp_wr) @(negedge clock);
  endtask

  // Bit by bit serial driver, then two idle bits
  task automatic drive_frame(byte_t data, logic par_bit, logic stop1, logic stop2,
                             logic noisy);
    logic [11:0] bits;
    int          nbits;
    int          lo;
    bits[0] = 1'b0;  // Start
    for (int i = 0; i < 8; i++) begin
      bits[i + 1] = data[i];
    end
    nbits = 9;
    if (parity_type inside {PARITY_EVEN, PARITY_ODD}) begin
      bits[nbits] = par_bit;
      nbits++;
    end
    bits[nbits] = stop1;
    nbits++;
    if (nstop) begin
      bits[nbits] = stop2;
      nbits++;
    end
    for (int b = 0; b < nbits; b++) begin
      // One tick wide window on sample 7, 8 or 9, after the two flop sync
      lo = (TICKS_PER_BIT / 2 - 1 + b % 3) * CLKS_PER_TICK + 1;
      for (int c = 0; c < BIT_CLKS; c++) begin
        @(negedge clock);
        rxd_drv = (noisy && c >= lo && c < lo + CLKS_PER_TICK) ? ~bits[b] : bits[b];
      end
    end
    @(negedge clock);
    rxd_drv = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge clock);
  endtask

  task automatic drive_checked(byte_t data, logic par_bit, logic stop1, logic stop2,
                               logic noisy);
    expect_entry(reference_entry(data, par_bit, stop1, stop2));
    drive_frame(data, par_bit, stop1, stop2, noisy);
  endtask

  // Start pulse of 5 ticks, too short for the centre samples
  task automatic drive_glitch();
    rxd_drv = 1'b0;
    repeat (5 * CLKS_PER_TICK) @(negedge clock);
    rxd_drv = 1'b1;
    repeat (3 * BIT_CLKS) @(negedge clock);
  endtask

  task automatic loopback_bytes(int count);
    byte_t data;
    for (int i = 0; i < count; i++) begin
      data = byte_t'($random(seed));
      while (!tx_ready) @(negedge clock);
      tx_data  = data;
      tx_valid = 1'b1;
      expect_entry(reference_entry(data, parity_bit_for(data, parity_type), 1'b1, 1'b1));
      @(negedge clock);
      tx_valid = 1'b0;
    end
    while (!tx_ready || exp_rd != exp_wr) @(negedge clock);
  endtask

  initial begin
    byte_t data;
    clock        = 1'b0;
    reset        = 1'b1;
    rx_en        = 1'b1;
    parity_type  = PARITY_NONE;
    nstop        = 1'b0;
    tx_data      = '0;
    tx_valid     = 1'b0;
    rx_ready     = 1'b1;
    rxd_drv      = 1'b1;
    use_loopback = 1'b1;
    test_name    = "reset";
    repeat (16) @(negedge clock);
    reset = 1'b0;
    assert (txd && tx_ready && !rx_valid && !rx_overrun) else begin
      stop_on_failure("Outputs are not at their reset values after reset");
    end

    test_name = "loopback";  // 20 bytes over all six formats
    set_format(PARITY_NONE, 1'b0);
    loopback_bytes(4);
    set_format(PARITY_NONE, 1'b1);
    loopback_bytes(4);
    set_format(PARITY_EVEN, 1'b0);
    loopback_bytes(3);
    set_format(PARITY_EVEN, 1'b1);
    loopback_bytes(3);
    set_format(PARITY_ODD, 1'b0);
    loopback_bytes(3);
    set_format(PARITY_ODD, 1'b1);
    loopback_bytes(3);
    use_loopback = 1'b0;

    test_name = "parity_error";
    set_format(PARITY_EVEN, 1'b0);
    data = byte_t'($random(seed));
    drive_checked(data, ~parity_bit_for(data, parity_type), 1'b1, 1'b1, 1'b0);
    set_format(PARITY_ODD, 1'b1);
    data = byte_t'($random(seed));
    drive_checked(data, ~parity_bit_for(data, parity_type), 1'b1, 1'b1, 1'b0);
    wait_drained();

    test_name = "frame_error";
    set_format(PARITY_NONE, 1'b0);
    drive_checked(byte_t'($random(seed)), 1'b0, 1'b0, 1'b1, 1'b0);  // Low stop1
    set_format(PARITY_EVEN, 1'b1);
    data = byte_t'($random(seed));
    drive_checked(data, parity_bit_for(data, parity_type), 1'b1, 1'b0, 1'b0);  // Low stop2
    wait_drained();

    test_name = "majority_vote";  // One bad sample per bit
    set_format(PARITY_ODD, 1'b1);
    data = byte_t'($random(seed));
    drive_checked(data, parity_bit_for(data, parity_type), 1'b1, 1'b1, 1'b1);
    wait_drained();

    test_name = "false_start";
    drive_glitch();

    test_name = "rx_disabled";
    rx_en = 1'b0;
    drive_frame(byte_t'($random(seed)), 1'b0, 1'b1, 1'b1, 1'b0);
    rx_en = 1'b1;

    test_name = "overrun";
    set_format(PARITY_NONE, 1'b0);
    assert (!rx_overrun) else begin
      stop_on_failure($sformatf("Error %s expected %b actual %b", test_name, 1'b0, rx_overrun));
    end
    rx_ready = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      drive_checked(byte_t'($random(seed)), 1'b0, 1'b1, 1'b1, 1'b0);
    end
    drive_frame(byte_t'($random(seed)), 1'b0, 1'b1, 1'b1, 1'b0);  // Dropped
    assert (rx_overrun) else begin
      stop_on_failure($sformatf("Error %s expected %b actual %b", test_name, 1'b1, rx_overrun));
    end
    rx_ready = 1'b1;
    wait_drained();
    repeat (4) @(negedge clock);

    if (exp_rd == exp_wr && !rx_valid && u_uart_core.u_uart_core_sva.error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_failure("Entries left over or a protocol assertion failed at the end of the run");
    end
  end

endmodule

/* vlog.f */
uart_pkg.sv
baud_tick_gen.sv
uart_tx.sv
uart_rx.sv
rx_queue.sv
uart_core.sv
uart_core_sva.sv
tb_uart_core.sv
